/* rtl/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Datapath word
`define CORE_DATA_W      32

// Low byte-address bits sent to each memory
`define CORE_MEM_ADDR_W  10

// Architectural register index
`define CORE_REG_ADDR_W  5

// Zicsr address field
`define CORE_CSR_ADDR_W  12

// Byte lanes per data word
`define CORE_STRB_W      4

// Fetch address after reset
`define CORE_RESET_PC    32'h0000_0000

`endif

/* rtl/core_pkg.sv */
`include "core_cfg.svh"

package core_pkg;

    typedef logic [`CORE_DATA_W-1:0]     word_t;      // Data word
    typedef logic [`CORE_MEM_ADDR_W-1:0] mem_addr_t;  // Memory byte address
    typedef logic [`CORE_REG_ADDR_W-1:0] reg_addr_t;  // x0..x31
    typedef logic [`CORE_CSR_ADDR_W-1:0] csr_addr_t;  // CSR number
    typedef logic [`CORE_STRB_W-1:0]     strb_t;      // One bit per byte lane

    typedef logic [3:0] alu_op_t;
    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLL    = 4'd2;
    localparam alu_op_t ALU_SLT    = 4'd3;
    localparam alu_op_t ALU_SLTU   = 4'd4;
    localparam alu_op_t ALU_XOR    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_OR     = 4'd8;
    localparam alu_op_t ALU_AND    = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10;  // LUI

    // Load/store width, same coding as funct3
    typedef logic [2:0] lsu_op_t;
    localparam lsu_op_t LSU_B  = 3'b000;
    localparam lsu_op_t LSU_H  = 3'b001;
    localparam lsu_op_t LSU_W  = 3'b010;
    localparam lsu_op_t LSU_BU = 3'b100;
    localparam lsu_op_t LSU_HU = 3'b101;

    typedef logic [2:0] br_op_t;
    localparam br_op_t BR_NONE = 3'd0;
    localparam br_op_t BR_JAL  = 3'd1;
    localparam br_op_t BR_JALR = 3'd2;
    localparam br_op_t BR_COND = 3'd3;  // Condition in br_funct3

    // Zicsr funct3, bit 2 selects the uimm form
    typedef logic [2:0] csr_op_t;
    localparam csr_op_t CSR_NONE = 3'b000;
    localparam csr_op_t CSR_RW   = 3'b001;
    localparam csr_op_t CSR_RS   = 3'b010;
    localparam csr_op_t CSR_RC   = 3'b011;

    typedef logic [1:0] opnd_sel_t;
    localparam opnd_sel_t OPND_RS2 = 2'd0;
    localparam opnd_sel_t OPND_IMM = 2'd1;

    typedef logic [1:0] wb_sel_t;
    localparam wb_sel_t WB_ALU  = 2'd0;
    localparam wb_sel_t WB_LOAD = 2'd1;
    localparam wb_sel_t WB_PC4  = 2'd2;
    localparam wb_sel_t WB_CSR  = 2'd3;

    typedef struct packed {
        alu_op_t    alu_op;
        lsu_op_t    lsu_op;
        br_op_t     br_op;
        logic [2:0] br_funct3;     // BEQ..BGEU
        csr_op_t    csr_op;
        logic       a_is_pc;       // Operand A is PC, else rs1
        opnd_sel_t  b_sel;
        wb_sel_t    wb_sel;
        logic       reg_we;
        logic       mem_we;
        logic       mem_re;
        logic       csr_uses_imm;  // CSR source is uimm, else rs1
    } ctrl_t;

endpackage

/* rtl/core_control_unit.sv */
`timescale 1ns/1ps

module core_control_unit (
    input  core_pkg::word_t     instr_i,
    output core_pkg::ctrl_t     ctrl_o,
    output core_pkg::reg_addr_t rs1_addr_o,
    output core_pkg::reg_addr_t rs2_addr_o,
    output core_pkg::reg_addr_t rd_addr_o,
    output core_pkg::word_t     imm_o,
    output core_pkg::csr_addr_t csr_addr_o
);

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic               alt;       // funct7[5], SUB and SRA
    core_pkg::word_t    imm_i, imm_s, imm_b, imm_u, imm_j, uimm;
    core_pkg::alu_op_t  alu_f3;    // ALU op for OP and OP-IMM

    assign opcode     = instr_i[6:0];
    assign funct3     = instr_i[14:12];
    assign alt        = instr_i[30];
    assign rd_addr_o  = instr_i[11:7];
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];
    assign csr_addr_o = instr_i[31:20];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};
    assign uimm  = {27'b0, instr_i[19:15]};  // Zero-extended rs1 field

    always_comb begin
        case (funct3)
            3'b000:  alu_f3 = (alt && opcode == OPC_OP) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001:  alu_f3 = core_pkg::ALU_SLL;
            3'b010:  alu_f3 = core_pkg::ALU_SLT;
            3'b011:  alu_f3 = core_pkg::ALU_SLTU;
            3'b100:  alu_f3 = core_pkg::ALU_XOR;
            3'b101:  alu_f3 = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;  // SRAI too
            3'b110:  alu_f3 = core_pkg::ALU_OR;
            default: alu_f3 = core_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        ctrl_o           = '0;                   // FENCE, ECALL, unknown: no-op
        ctrl_o.alu_op    = core_pkg::ALU_ADD;    // Also address and JALR sum
        ctrl_o.lsu_op    = funct3;
        ctrl_o.br_funct3 = funct3;
        ctrl_o.b_sel     = core_pkg::OPND_IMM;
        ctrl_o.wb_sel    = core_pkg::WB_ALU;
        imm_o            = imm_i;
        case (opcode)
            OPC_LUI: begin
                ctrl_o.alu_op = core_pkg::ALU_PASS_B;
                ctrl_o.reg_we = 1'b1;
                imm_o         = imm_u;
            end
            OPC_AUIPC: begin
                ctrl_o.a_is_pc = 1'b1;           // PC + upper imm
                ctrl_o.reg_we  = 1'b1;
                imm_o          = imm_u;
            end
            OPC_JAL: begin
                ctrl_o.br_op  = core_pkg::BR_JAL;
                ctrl_o.wb_sel = core_pkg::WB_PC4;  // Link
                ctrl_o.reg_we = 1'b1;
                imm_o         = imm_j;
            end
            OPC_JALR: begin
                ctrl_o.br_op  = core_pkg::BR_JALR;
                ctrl_o.wb_sel = core_pkg::WB_PC4;
                ctrl_o.reg_we = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl_o.br_op = core_pkg::BR_COND;
                ctrl_o.b_sel = core_pkg::OPND_RS2;
                imm_o        = imm_b;
            end
            OPC_LOAD: begin
                ctrl_o.mem_re = 1'b1;
                ctrl_o.wb_sel = core_pkg::WB_LOAD;
                ctrl_o.reg_we = 1'b1;
            end
            OPC_STORE: begin
                ctrl_o.mem_we = 1'b1;
                imm_o         = imm_s;
            end
            OPC_OP_IMM: begin
                ctrl_o.alu_op = alu_f3;
                ctrl_o.reg_we = 1'b1;
            end
            OPC_OP: begin
                ctrl_o.alu_op = alu_f3;
                ctrl_o.b_sel  = core_pkg::OPND_RS2;
                ctrl_o.reg_we = 1'b1;
            end
            OPC_SYSTEM: begin
                imm_o = uimm;                    // CSR immediate source
                if (funct3 != 3'b000) begin      // funct3 0 is ECALL/EBREAK
                    ctrl_o.csr_op       = funct3;
                    ctrl_o.csr_uses_imm = funct3[2];
                    ctrl_o.wb_sel       = core_pkg::WB_CSR;  // Old CSR value to rd
                    ctrl_o.reg_we       = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

/* rtl/core_program_counter.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_program_counter (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            redirect_valid_i,  // Taken branch or jump
    input  core_pkg::word_t redirect_pc_i,
    output core_pkg::word_t pc_o,
    output core_pkg::word_t pc_plus4_o         // Also link value
);

    assign pc_plus4_o = pc_o + core_pkg::word_t'(4);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_o <= `CORE_RESET_PC;
        end else begin
            pc_o <= redirect_valid_i ? redirect_pc_i : pc_plus4_o;  // One instr per clock
        end
    end

    // Targets come from the execution unit, fetch needs word alignment
    assert property (@(posedge clk) disable iff (!rst_n_i) pc_o[1:0] == 2'b00)
        else $error("PC not word aligned: %h", pc_o);

endmodule

/* rtl/core_regfile.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_regfile (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                we_i,
    input  core_pkg::reg_addr_t rs1_addr_i,
    input  core_pkg::reg_addr_t rs2_addr_i,
    input  core_pkg::reg_addr_t rd_addr_i,
    input  core_pkg::word_t     rd_data_i,
    output core_pkg::word_t     rs1_data_o,
    output core_pkg::word_t     rs2_data_o
);

    localparam int NUM_REGS = 1 << `CORE_REG_ADDR_W;

    core_pkg::word_t regs [NUM_REGS];  // x0 entry cleared on reset, never written

    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_addr_i != '0) begin  // Writes to x0 dropped
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    // x0 stays zero even after write-back tries to target it
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (rs1_addr_i != '0 || rs1_data_o == '0) && (rs2_addr_i != '0 || rs2_data_o == '0))
        else $error("x0 read back nonzero");

endmodule

/* rtl/core_execution_unit.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_execution_unit (
    input  core_pkg::ctrl_t     ctrl_i,
    input  core_pkg::word_t     rs1_i,
    input  core_pkg::word_t     rs2_i,
    input  core_pkg::word_t     imm_i,
    input  core_pkg::word_t     pc_i,
    input  core_pkg::word_t     pc_plus4_i,
    input  core_pkg::word_t     csr_rdata_i,
    input  core_pkg::word_t     mem_rdata_i,
    output core_pkg::word_t     wb_data_o,
    output core_pkg::word_t     csr_wdata_o,
    output core_pkg::word_t     mem_wdata_o,
    output core_pkg::mem_addr_t mem_addr_o,
    output core_pkg::strb_t     mem_strb_o,
    output logic                mem_we_o,
    output logic                redirect_valid_o,
    output core_pkg::word_t     redirect_pc_o
);

    core_pkg::word_t op_a, op_b, alu_res, ld_shift, ld_val;
    logic            br_take;
    logic [1:0]      byte_off;  // Lane of the access

    assign op_a     = ctrl_i.a_is_pc ? pc_i : rs1_i;
    assign op_b     = (ctrl_i.b_sel == core_pkg::OPND_IMM) ? imm_i : rs2_i;
    assign byte_off = alu_res[1:0];

    always_comb begin
        case (ctrl_i.alu_op)
            core_pkg::ALU_ADD:    alu_res = op_a + op_b;
            core_pkg::ALU_SUB:    alu_res = op_a - op_b;
            core_pkg::ALU_SLL:    alu_res = op_a << op_b[4:0];
            core_pkg::ALU_SLT:    alu_res = {{(`CORE_DATA_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            core_pkg::ALU_SLTU:   alu_res = {{(`CORE_DATA_W-1){1'b0}}, op_a < op_b};
            core_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
            core_pkg::ALU_SRL:    alu_res = op_a >> op_b[4:0];
            core_pkg::ALU_SRA:    alu_res = core_pkg::word_t'($signed(op_a) >>> op_b[4:0]);
            core_pkg::ALU_OR:     alu_res = op_a | op_b;
            core_pkg::ALU_AND:    alu_res = op_a & op_b;
            core_pkg::ALU_PASS_B: alu_res = op_b;
            default:              alu_res = '0;
        endcase
    end

    always_comb begin
        case (ctrl_i.br_funct3)
            3'b000:  br_take = (rs1_i == rs2_i);                  // BEQ
            3'b001:  br_take = (rs1_i != rs2_i);                  // BNE
            3'b100:  br_take = ($signed(rs1_i) < $signed(rs2_i));  // BLT
            3'b101:  br_take = ($signed(rs1_i) >= $signed(rs2_i)); // BGE
            3'b110:  br_take = (rs1_i < rs2_i);                   // BLTU
            3'b111:  br_take = (rs1_i >= rs2_i);                  // BGEU
            default: br_take = 1'b0;
        endcase
        case (ctrl_i.br_op)
            core_pkg::BR_NONE: redirect_valid_o = 1'b0;
            core_pkg::BR_JAL:  redirect_valid_o = 1'b1;
            core_pkg::BR_JALR: redirect_valid_o = 1'b1;
            core_pkg::BR_COND: redirect_valid_o = br_take;
            default:           redirect_valid_o = 1'b0;
        endcase
    end

    // JALR target is the ALU sum rs1 + imm with bit 0 cleared
    assign redirect_pc_o = (ctrl_i.br_op == core_pkg::BR_JALR) ?
                           {alu_res[`CORE_DATA_W-1:1], 1'b0} : pc_i + imm_i;

    assign mem_addr_o  = alu_res[`CORE_MEM_ADDR_W-1:0];
    assign mem_we_o    = ctrl_i.mem_we;
    assign csr_wdata_o = ctrl_i.csr_uses_imm ? imm_i : rs1_i;  // uimm sits in imm

    always_comb begin
        case (ctrl_i.lsu_op)
            core_pkg::LSU_B: begin
                mem_wdata_o = {4{rs2_i[7:0]}};       // Byte copied to every lane
                mem_strb_o  = 4'b0001 << byte_off;
            end
            core_pkg::LSU_H: begin
                mem_wdata_o = {2{rs2_i[15:0]}};
                mem_strb_o  = 4'b0011 << {byte_off[1], 1'b0};
            end
            default: begin
                mem_wdata_o = rs2_i;
                mem_strb_o  = 4'b1111;
            end
        endcase
        if (!ctrl_i.mem_we) mem_strb_o = '0;        // Lanes quiet unless storing
    end

    assign ld_shift = mem_rdata_i >> {byte_off, 3'b000};  // Addressed lane to bit 0

    always_comb begin
        case (ctrl_i.lsu_op)
            core_pkg::LSU_B:  ld_val = {{24{ld_shift[7]}}, ld_shift[7:0]};
            core_pkg::LSU_H:  ld_val = {{16{ld_shift[15]}}, ld_shift[15:0]};
            core_pkg::LSU_W:  ld_val = mem_rdata_i;
            core_pkg::LSU_BU: ld_val = {24'b0, ld_shift[7:0]};
            core_pkg::LSU_HU: ld_val = {16'b0, ld_shift[15:0]};
            default:          ld_val = '0;
        endcase
        if (!ctrl_i.mem_re) ld_val = '0;
    end

    always_comb begin
        case (ctrl_i.wb_sel)
            core_pkg::WB_ALU:  wb_data_o = alu_res;
            core_pkg::WB_LOAD: wb_data_o = ld_val;
            core_pkg::WB_PC4:  wb_data_o = pc_plus4_i;
            core_pkg::WB_CSR:  wb_data_o = csr_rdata_i;  // Old CSR value
        endcase
    end

endmodule

/* rtl/core_csr_unit.sv */
`timescale 1ns/1ps

module core_csr_unit (
    input  logic                clk,
    input  logic                rst_n_i,
    input  core_pkg::csr_op_t   csr_op_i,
    input  core_pkg::csr_addr_t csr_addr_i,
    input  core_pkg::word_t     csr_wdata_i,  // rs1 or uimm
    output core_pkg::word_t     csr_rdata_o
);

    localparam core_pkg::csr_addr_t MSCRATCH_ADDR = 12'h340;
    localparam core_pkg::csr_addr_t MEPC_ADDR     = 12'h341;

    core_pkg::word_t mscratch_q, mepc_q, new_val;
    logic            wr_en;

    always_comb begin
        case (csr_addr_i)
            MSCRATCH_ADDR: csr_rdata_o = mscratch_q;
            MEPC_ADDR:     csr_rdata_o = mepc_q;
            default:       csr_rdata_o = '0;  // Unimplemented reads zero
        endcase
    end

    always_comb begin
        wr_en   = (csr_op_i != core_pkg::CSR_NONE);
        new_val = csr_rdata_o;
        case ({1'b0, csr_op_i[1:0]})          // Immediate forms share the update
            core_pkg::CSR_RW: new_val = csr_wdata_i;
            core_pkg::CSR_RS: begin
                new_val = csr_rdata_o | csr_wdata_i;
                wr_en   = wr_en && (csr_wdata_i != '0);  // Zero source is read only
            end
            core_pkg::CSR_RC: begin
                new_val = csr_rdata_o & ~csr_wdata_i;
                wr_en   = wr_en && (csr_wdata_i != '0);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mscratch_q <= '0;
            mepc_q     <= '0;
        end else if (wr_en) begin
            if (csr_addr_i == MSCRATCH_ADDR) mscratch_q <= new_val;
            if (csr_addr_i == MEPC_ADDR) mepc_q <= new_val;
        end
    end

endmodule

/* rtl/core.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module core (
    input  logic                clk,
    input  logic                rst_n_i,
    output core_pkg::mem_addr_t prog_addr_o,
    input  core_pkg::word_t     prog_data_i,   // Instruction, same cycle
    output core_pkg::mem_addr_t data_addr_o,
    output core_pkg::word_t     data_wdata_o,
    input  core_pkg::word_t     data_rdata_i,
    output core_pkg::strb_t     data_strb_o,
    output logic                data_we_o
);

    core_pkg::ctrl_t     ctrl;
    core_pkg::reg_addr_t rs1_addr, rs2_addr, rd_addr;
    core_pkg::csr_addr_t csr_addr;
    core_pkg::word_t     imm, rs1_data, rs2_data, wb_data;
    core_pkg::word_t     pc, pc_plus4, redirect_pc, csr_wdata, csr_rdata;
    logic                redirect_valid;

    assign prog_addr_o = pc[`CORE_MEM_ADDR_W-1:0];  // Low PC bits fetch

    core_control_unit control_unit_inst (
        .instr_i    (prog_data_i),
        .ctrl_o     (ctrl),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rd_addr_o  (rd_addr),
        .imm_o      (imm),
        .csr_addr_o (csr_addr)
    );

    core_program_counter program_counter_inst (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .pc_o             (pc),
        .pc_plus4_o       (pc_plus4)
    );

    core_regfile regfile_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .we_i       (ctrl.reg_we),               // Straight from decode
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rd_addr_i  (rd_addr),
        .rd_data_i  (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    core_execution_unit execution_unit_inst (
        .ctrl_i           (ctrl),
        .rs1_i            (rs1_data),
        .rs2_i            (rs2_data),
        .imm_i            (imm),
        .pc_i             (pc),
        .pc_plus4_i       (pc_plus4),
        .csr_rdata_i      (csr_rdata),
        .mem_rdata_i      (data_rdata_i),
        .wb_data_o        (wb_data),
        .csr_wdata_o      (csr_wdata),
        .mem_wdata_o      (data_wdata_o),
        .mem_addr_o       (data_addr_o),
        .mem_strb_o       (data_strb_o),
        .mem_we_o         (data_we_o),
        .redirect_valid_o (redirect_valid),
        .redirect_pc_o    (redirect_pc)
    );

    core_csr_unit csr_unit_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .csr_op_i    (ctrl.csr_op),
        .csr_addr_i  (csr_addr),
        .csr_wdata_i (csr_wdata),
        .csr_rdata_o (csr_rdata)
    );

endmodule

/* bench/core_tb_mem.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_tb_mem (
    input  logic                clk,
    input  logic                rst_n_i,
    input  core_pkg::mem_addr_t prog_addr_i,
    output core_pkg::word_t     prog_data_o,
    input  core_pkg::mem_addr_t data_addr_i,
    input  core_pkg::word_t     data_wdata_i,
    output core_pkg::word_t     data_rdata_o,
    input  core_pkg::strb_t     data_strb_i,
    input  logic                data_we_i
);

    localparam int WORDS = 1 << (`CORE_MEM_ADDR_W - 2);
    localparam core_pkg::word_t NOP = 32'h0000_0013;  // addi x0, x0, 0

    core_pkg::word_t rom [WORDS];  // Filled by the testbench
    core_pkg::word_t ram [WORDS];
    logic [`CORE_MEM_ADDR_W-3:0] data_word;   // Word index of data access

    assign data_word    = data_addr_i[`CORE_MEM_ADDR_W-1:2];
    assign prog_data_o  = rst_n_i ? rom[prog_addr_i[`CORE_MEM_ADDR_W-1:2]] : NOP;  // NOP in reset
    assign data_rdata_o = ram[data_word];                     // Same-cycle read

    // Byte-lane write at the edge that retires the store
    always @(posedge clk) begin
        if (data_we_i) begin
            for (int b = 0; b < `CORE_STRB_W; b++) begin
                if (data_strb_i[b]) begin
                    ram[data_word][8*b +: 8] <= data_wdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule

/* bench/core_tb.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_tb;

    localparam int RAM_WORDS     = 1 << (`CORE_MEM_ADDR_W - 2);
    localparam int STORE_TIMEOUT = 200;  // Cycles allowed per store
    localparam int QUIET_CYCLES  = 20;   // Self-loop with no store
    localparam int BASE          = 32'h100;  // x1, result area
    localparam int POISON        = 252;      // Marker offset, must never be written
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    typedef struct packed {
        core_pkg::mem_addr_t pc;     // Fetch address of the store
        core_pkg::mem_addr_t addr;
        core_pkg::strb_t     strb;
        core_pkg::word_t     data;   // Strobed lanes only
    } store_t;

    logic                clk, rst_n, data_we;
    core_pkg::mem_addr_t prog_addr, data_addr;
    core_pkg::word_t     prog_data, data_wdata, data_rdata;
    core_pkg::strb_t     data_strb;

    core_pkg::word_t prog [$];
    core_pkg::word_t ram_copy [RAM_WORDS];  // Initial RAM, for load prediction
    store_t          expected [$];

    core core_inst (
        .clk (clk), .rst_n_i (rst_n),
        .prog_addr_o (prog_addr), .prog_data_i (prog_data),
        .data_addr_o (data_addr), .data_wdata_o (data_wdata), .data_rdata_i (data_rdata),
        .data_strb_o (data_strb), .data_we_o (data_we)
    );

    core_tb_mem mem_inst (
        .clk (clk), .rst_n_i (rst_n),
        .prog_addr_i (prog_addr), .prog_data_o (prog_data),
        .data_addr_i (data_addr), .data_wdata_i (data_wdata), .data_rdata_o (data_rdata),
        .data_strb_i (data_strb), .data_we_i (data_we)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    function automatic core_pkg::word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                               input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic core_pkg::word_t i_type(input logic [6:0] opc, input logic [2:0] f3,
                                               input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    // sw/sh/sb rs2, imm(rs1)
    function automatic core_pkg::word_t s_type(input logic [2:0] f3, input int rs1,
                                               input int rs2, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic core_pkg::word_t b_type(input logic [2:0] f3, input int rs1,
                                               input int rs2, input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic core_pkg::word_t u_type(input logic [6:0] opc, input int rd,
                                               input int imm20);
        return {imm20[19:0], rd[4:0], opc};
    endfunction

    function automatic core_pkg::word_t j_type(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic void emit(input core_pkg::word_t instr);
        prog.push_back(instr);
    endfunction

    function automatic void expect_store(input int off, input core_pkg::strb_t strb,
                                         input core_pkg::word_t data);
        core_pkg::mem_addr_t pc;
        pc = core_pkg::mem_addr_t'((prog.size() - 1) * 4);  // Store was just emitted
        expected.push_back('{pc, core_pkg::mem_addr_t'(BASE + off), strb, data});
    endfunction

    function automatic void store_and_expect(input int rs2, input int off,
                                             input core_pkg::word_t data);
        emit(s_type(3'b010, 1, rs2, off));  // sw rs2, off(x1)
        expect_store(off, 4'b1111, data);
    endfunction

    function automatic void poison_store();
        emit(s_type(3'b010, 1, 2, POISON));  // Only reached if control flow is wrong
    endfunction

    function automatic core_pkg::word_t lane_mask(input core_pkg::strb_t strb);
        core_pkg::word_t m;
        for (int b = 0; b < `CORE_STRB_W; b++) begin
            m[8*b +: 8] = {8{strb[b]}};
        end
        return m;
    endfunction

    task automatic build_program();
        core_pkg::word_t w;
        int              pc_aui, pc_j, pc_q;
        w = ram_copy[32];                                  // Word at 0x80
        emit(i_type(OPC_OP_IMM, 3'b000, 1, 0, BASE));      // addi x1, x0, 0x100
        emit(i_type(OPC_OP_IMM, 3'b000, 2, 0, -5));        // x2 = -5
        emit(i_type(OPC_OP_IMM, 3'b000, 3, 0, 12));        // x3 = 12
        emit(r_type(7'h00, 3'b000, 4, 2, 3));              // add
        store_and_expect(4, 0, 32'd7);
        emit(r_type(7'h20, 3'b000, 5, 3, 2));              // sub x5, x3, x2
        store_and_expect(5, 4, 32'd17);
        emit(i_type(OPC_OP_IMM, 3'b001, 6, 3, 4));         // slli
        emit(i_type(OPC_OP_IMM, 3'b101, 7, 2, 12'h401));   // srai by 1
        emit(i_type(OPC_OP_IMM, 3'b101, 8, 2, 28));        // srli
        emit(r_type(7'h00, 3'b001, 15, 3, 3));             // sll by register
        store_and_expect(6, 8, 32'h0000_00C0);
        store_and_expect(7, 12, 32'hFFFF_FFFD);
        store_and_expect(8, 16, 32'h0000_000F);
        store_and_expect(15, 20, 32'h0000_C000);
        emit(r_type(7'h00, 3'b010, 9, 2, 3));              // slt, signed -5 < 12
        emit(r_type(7'h00, 3'b011, 10, 2, 3));             // sltu, huge vs 12
        store_and_expect(9, 24, 32'd1);
        store_and_expect(10, 28, 32'd0);
        emit(i_type(OPC_OP_IMM, 3'b100, 11, 2, 12'h0F0));  // xori
        emit(r_type(7'h00, 3'b110, 12, 3, 6));             // or
        emit(i_type(OPC_OP_IMM, 3'b111, 13, 2, 12'h7FF));  // andi
        store_and_expect(11, 32, 32'hFFFF_FF0B);
        store_and_expect(12, 36, 32'h0000_00CC);
        store_and_expect(13, 40, 32'h0000_07FB);
        emit(u_type(OPC_LUI, 14, 20'h12345));
        emit(i_type(OPC_OP_IMM, 3'b000, 14, 14, 12'h678));
        store_and_expect(14, 44, 32'h1234_5678);
        pc_aui = prog.size() * 4;
        emit(u_type(OPC_AUIPC, 15, 20'h00001));            // PC + 0x1000
        store_and_expect(15, 48, pc_aui + 32'h1000);
        emit(s_type(3'b000, 1, 14, 53));                   // sb, lane 1
        expect_store(53, 4'b0010, 32'h0000_7800);
        emit(s_type(3'b001, 1, 14, 58));                   // sh, upper half
        expect_store(58, 4'b1100, 32'h5678_0000);
        emit(s_type(3'b000, 1, 2, 63));                    // sb, lane 3
        expect_store(63, 4'b1000, 32'hFB00_0000);
        emit(i_type(OPC_OP_IMM, 3'b000, 16, 0, 12'h080));  // x16 = 0x80
        emit(i_type(OPC_LOAD, 3'b000, 17, 16, 1));         // lb
        store_and_expect(17, 64, {{24{w[15]}}, w[15:8]});
        emit(i_type(OPC_LOAD, 3'b100, 18, 16, 3));         // lbu
        store_and_expect(18, 68, {24'b0, w[31:24]});
        emit(i_type(OPC_LOAD, 3'b001, 19, 16, 2));         // lh
        store_and_expect(19, 72, {{16{w[31]}}, w[31:16]});
        emit(i_type(OPC_LOAD, 3'b101, 20, 16, 0));         // lhu
        store_and_expect(20, 76, {16'b0, w[15:0]});
        emit(i_type(OPC_LOAD, 3'b010, 21, 16, 4));         // lw
        store_and_expect(21, 80, ram_copy[33]);
        emit(b_type(3'b000, 3, 3, 8));                     // beq, taken
        poison_store();
        emit(b_type(3'b001, 3, 3, 8));                     // bne, falls through
        store_and_expect(3, 84, 32'd12);
        emit(b_type(3'b100, 2, 3, 8));                     // blt, taken
        poison_store();
        emit(b_type(3'b101, 2, 3, 8));                     // bge, falls through
        store_and_expect(3, 88, 32'd12);
        emit(b_type(3'b110, 2, 3, 8));                     // bltu, falls through
        store_and_expect(2, 92, 32'hFFFF_FFFB);
        emit(b_type(3'b111, 2, 3, 8));                     // bgeu, taken
        poison_store();
        pc_j = prog.size() * 4;
        emit(j_type(23, 8));                               // jal x23, +8
        poison_store();
        store_and_expect(23, 96, pc_j + 4);
        pc_q = prog.size() * 4;
        emit(u_type(OPC_AUIPC, 24, 0));
        emit(i_type(OPC_JALR, 3'b000, 25, 24, 12));        // jalr x25, 12(x24)
        poison_store();
        store_and_expect(25, 100, pc_q + 8);
        emit(i_type(OPC_SYSTEM, 3'b001, 26, 14, 12'h340)); // csrrw mscratch
        store_and_expect(26, 104, 32'd0);
        emit(i_type(OPC_SYSTEM, 3'b010, 27, 3, 12'h340));  // csrrs, set 0xC
        store_and_expect(27, 108, 32'h1234_5678);
        emit(i_type(OPC_SYSTEM, 3'b011, 28, 6, 12'h340));  // csrrc, clear 0xC0
        store_and_expect(28, 112, 32'h1234_567C);
        emit(i_type(OPC_SYSTEM, 3'b110, 29, 3, 12'h340));  // csrrsi 3
        store_and_expect(29, 116, 32'h1234_563C);
        emit(i_type(OPC_SYSTEM, 3'b111, 30, 31, 12'h340)); // csrrci 0x1F
        store_and_expect(30, 120, 32'h1234_563F);
        emit(i_type(OPC_SYSTEM, 3'b010, 31, 0, 12'h340));  // csrrs x0 source, read only
        store_and_expect(31, 124, 32'h1234_5620);
        emit(i_type(OPC_SYSTEM, 3'b001, 0, 3, 12'h341));   // mepc = 12
        emit(i_type(OPC_SYSTEM, 3'b010, 5, 0, 12'h341));
        store_and_expect(5, 128, 32'd12);
        emit(i_type(OPC_SYSTEM, 3'b101, 4, 5, 12'h7C0));   // Unimplemented CSR
        store_and_expect(4, 132, 32'd0);
        emit(j_type(0, 0));                                // Self-loop
    endtask

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_addr(input core_pkg::mem_addr_t got, input core_pkg::mem_addr_t exp,
                              input int idx, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: store %0d %s 0x%h, expected 0x%h",
                     $time, idx, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_strb(input core_pkg::strb_t got, input core_pkg::strb_t exp,
                              input int idx);
        if (got !== exp) begin
            $display("** Error at %0t: store %0d strobe %b, expected %b", $time, idx, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input core_pkg::word_t got, input core_pkg::word_t exp,
                              input int idx);
        if (got !== exp) begin
            $display("** Error at %0t: store %0d data 0x%h, expected 0x%h",
                     $time, idx, got, exp);
            abort_run();
        end
    endtask

    initial begin
        int waited;
        void'($urandom(54152));
        rst_n = 1'b0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram_copy[i] = $urandom;
        end
        ram_copy[32] = ram_copy[32] | 32'h8080_8080;  // Negative bytes and halves for loads
        build_program();
        for (int i = 0; i < prog.size(); i++) begin
            mem_inst.rom[i] = prog[i];
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem_inst.ram[i] = ram_copy[i];
        end

        for (int c = 0; c < 4; c++) begin   // Reset held 4 cycles
            @(negedge clk);
            if (data_we) begin
                $display("Data write enable went high during reset at time %0t", $time);
                abort_run();
            end
        end
        rst_n = 1'b1;

        foreach (expected[n]) begin
            waited = 0;
            @(negedge clk);                 // Outputs settled since the rising edge
            while (!data_we && waited < STORE_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!data_we) begin
                $display("No store %0d seen within %0d cycles", n, STORE_TIMEOUT);
                abort_run();
            end
            check_addr(prog_addr, expected[n].pc, n, "fetch address");
            check_addr(data_addr, expected[n].addr, n, "address");
            check_strb(data_strb, expected[n].strb, n);
            check_word(data_wdata & lane_mask(expected[n].strb), expected[n].data, n);
        end

        for (int c = 0; c < QUIET_CYCLES; c++) begin
            @(negedge clk);
            if (data_we) begin
                $display("Unexpected store to 0x%h after the last expected one", data_addr);
                abort_run();
            end
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* list.f */
+incdir+rtl
rtl/core_pkg.sv
rtl/core_control_unit.sv
rtl/core_program_counter.sv
rtl/core_regfile.sv
rtl/core_execution_unit.sv
rtl/core_csr_unit.sv
rtl/core.sv
bench/core_tb_mem.sv
bench/core_tb.sv
